/* spi_burst.f */
+incdir+logic
logic/spi_bus_pkg.sv
logic/spi_burst_pkg.sv
logic/byte_table.sv
logic/spi_shift_engine.sv
logic/burst_sequencer.sv
logic/spi_burst_top.sv
tests/spi_slave_model.sv
tests/spi_burst_tb.sv

/* Bender.yml */
package:
  name: spi_burst

sources:
  - include_dirs:
      - logic
    files:
      - logic/spi_bus_pkg.sv
      - logic/spi_burst_pkg.sv
      - logic/byte_table.sv
      - logic/spi_shift_engine.sv
      - logic/burst_sequencer.sv
      - logic/spi_burst_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/spi_slave_model.sv
      - tests/spi_burst_tb.sv

/* tests/spi_burst_tb.sv */
`default_nettype none

`include "spi_burst_cfg.svh"

module spi_burst_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import spi_bus_pkg::*;
    import spi_burst_pkg::*;

    localparam int MAX         = `SPI_BURST_MAX_XFERS;
    localparam int NUM_BURSTS  = 10;
    localparam int CYCLE_LIMIT = NUM_BURSTS * (MAX * 16 * `SPI_BURST_CLK_DIV + 10) + 200;

    logic      clk;
    logic      rst;
    logic      tx_wr;
    xfer_idx_t tx_waddr;
    spi_byte_t tx_wdata;
    xfer_idx_t rx_raddr;
    spi_byte_t rx_rdata;
    xfer_cnt_t xfer_count;
    logic      start;
    logic      burst_busy;
    logic      done;
    logic      sclk;
    logic      mosi;
    logic      cs_n;
    logic      miso;
    spi_byte_t tx_ref [MAX];
    int        cycles = 0;
    int        done_cnt = 0;
    int        rec_base = 0;

    spi_burst_top DUT (
        .clk(clk), .rst(rst), .tx_wr(tx_wr), .tx_waddr(tx_waddr), .tx_wdata(tx_wdata),
        .rx_raddr(rx_raddr), .rx_rdata(rx_rdata), .xfer_count(xfer_count), .start(start),
        .burst_busy(burst_busy), .done(done), .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
        .miso(miso)
    );

    spi_slave_model u_slave (.sclk(sclk), .mosi(mosi), .cs_n(cs_n), .miso(miso));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp)
            else abort_run($sformatf("mismatch %s: expected 0x%0h, got 0x%0h", name, exp, act));
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #1;                                     // inputs change just after the edge
    endtask

    task automatic check_quiet_outputs();
        expect_value("cs_n", 1, cs_n);
        expect_value("sclk", 0, sclk);
        expect_value("done", 0, done);
        expect_value("burst_busy", 0, burst_busy);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pin protocol checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assert property (@(posedge clk) disable iff (rst) $rose(cs_n) |-> done)
        else abort_run("cs_n went high in the middle of a burst");
    assert property (@(posedge clk) disable iff (rst) done |=> (cs_n && !done))
        else abort_run("done was not a single pulse followed by cs_n high");
    assert property (@(posedge clk) disable iff (rst) (sclk != $past(sclk)) |-> !cs_n)
        else abort_run("sclk toggled while cs_n was high");
    assert property (@(posedge clk) disable iff (rst) done |-> burst_busy)
        else abort_run("burst_busy was low in the done cycle");

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (done === 1'b1) begin
            done_cnt = done_cnt + 1;
        end
        if (cycles > CYCLE_LIMIT) begin
            abort_run("timeout: bursts did not finish within the cycle budget");
        end
    end

    task automatic load_tx_table();
        for (int i = 0; i < MAX; i++) begin
            tx_ref[i] = spi_byte_t'($urandom);
            next_drive_slot();
            tx_wr    = 1'b1;
            tx_waddr = xfer_idx_t'(i);
            tx_wdata = tx_ref[i];
        end
        next_drive_slot();
        tx_wr = 1'b0;
    endtask

    task automatic run_burst(input int n, input int bursts_so_far);
        int resp_base;
        resp_base = u_slave.resp_ptr;
        next_drive_slot();
        xfer_count = xfer_cnt_t'(n);
        start      = 1'b1;
        next_drive_slot();
        start = 1'b0;
        repeat (10) next_drive_slot();
        expect_value("burst_busy", 1, burst_busy);
        start = 1'b1;                           // second start lands mid burst
        next_drive_slot();
        start = 1'b0;
        do @(negedge clk); while (done !== 1'b1);
        repeat (3) @(negedge clk);
        check_quiet_outputs();
        expect_value("done count", bursts_so_far + 1, done_cnt);
        expect_value("mosi byte count", rec_base + n, u_slave.rec_cnt);
        for (int i = 0; i < n; i++) begin
            expect_value($sformatf("mosi[%0d]", i), tx_ref[i], u_slave.rec_mem[rec_base + i]);
            next_drive_slot();
            rx_raddr = xfer_idx_t'(i);
            @(negedge clk);
            expect_value($sformatf("rx_rdata[%0d]", i), u_slave.resp_mem[resp_base + i],
                         rx_rdata);
        end
        rec_base = rec_base + n;
    endtask

    initial begin
        int n;
        void'($urandom(10));
        rst        = 1'b1;
        tx_wr      = 1'b0;
        tx_waddr   = '0;
        tx_wdata   = '0;
        rx_raddr   = '0;
        xfer_count = '0;
        start      = 1'b0;
        for (int i = 0; i < 256; i++) begin
            u_slave.resp_mem[i] = spi_byte_t'($urandom);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_quiet_outputs();                  // still in reset
        next_drive_slot();
        rst = 1'b0;
        @(negedge clk);
        check_quiet_outputs();
        for (int i = 0; i < MAX; i++) begin
            next_drive_slot();
            rx_raddr = xfer_idx_t'(i);
            @(negedge clk);
            expect_value($sformatf("rx_rdata[%0d]", i), 0, rx_rdata);
        end
        for (int b = 0; b < NUM_BURSTS; b++) begin
            n = (b == 0) ? 1 : (b == 1) ? MAX : 1 + int'($urandom % MAX);
            load_tx_table();
            run_burst(n, b);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/spi_slave_model.sv */
`default_nettype none

module spi_slave_model (
    input  wire logic sclk,
    input  wire logic mosi,
    input  wire logic cs_n,
    output logic      miso
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 256;

    logic [7:0] resp_mem [DEPTH];               // loaded by the testbench
    logic [7:0] rec_mem [DEPTH];                // mosi bytes in arrival order
    int         resp_ptr;
    int         rec_cnt;
    int         bit_cnt;
    logic [7:0] in_sr;
    logic [7:0] out_sr;

    initial begin
        miso     = 1'b0;
        resp_ptr = 0;
        rec_cnt  = 0;
        bit_cnt  = 0;
        in_sr    = '0;
        out_sr   = '0;
    end

    // first response bit sits on miso before the first rising sclk
    always @(negedge cs_n) begin
        bit_cnt = 0;
        out_sr  = resp_mem[resp_ptr];
        miso    = out_sr[7];
    end

    always @(posedge sclk) begin
        if (cs_n === 1'b0) begin
            in_sr   = {in_sr[6:0], mosi};       // mode 0 sample
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                rec_mem[rec_cnt] = in_sr;
                rec_cnt  = rec_cnt + 1;
                resp_ptr = resp_ptr + 1;
                bit_cnt  = 0;
            end
        end
    end

    always @(negedge sclk) begin
        if (cs_n === 1'b0) begin
            if (bit_cnt == 0) begin
                out_sr = resp_mem[resp_ptr];    // next byte of the same burst
            end else begin
                out_sr = {out_sr[6:0], 1'b0};
            end
            miso = out_sr[7];
        end
    end

endmodule

`default_nettype wire

/* logic/spi_burst_top.sv */
`default_nettype none

module spi_burst_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    // transmit table load
    input  wire logic                     tx_wr,
    input  wire spi_burst_pkg::xfer_idx_t tx_waddr,
    input  wire spi_bus_pkg::spi_byte_t   tx_wdata,
    // receive table read
    input  wire spi_burst_pkg::xfer_idx_t rx_raddr,
    output spi_bus_pkg::spi_byte_t        rx_rdata,
    // burst control and status
    input  wire spi_burst_pkg::xfer_cnt_t xfer_count,
    input  wire logic                     start,
    output logic                          burst_busy,
    output logic                          done,
    // spi pins
    output logic                          sclk,
    output logic                          mosi,
    output logic                          cs_n,
    input  wire logic                     miso
);
    import spi_bus_pkg::*;
    import spi_burst_pkg::*;

    xfer_idx_t index;
    spi_byte_t tx_data;
    spi_byte_t rx_data;
    logic      start_spi;
    logic      busy;
    logic      new_data;
    logic      rx_wr;

    byte_table u_tx_table (
        .clk   (clk),
        .rst   (rst),
        .wr    (tx_wr),
        .waddr (tx_waddr),
        .wdata (tx_wdata),
        .raddr (index),
        .rdata (tx_data)
    );

    burst_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .xfer_count (xfer_count),
        .busy       (busy),
        .new_data   (new_data),
        .index      (index),
        .start_spi  (start_spi),
        .rx_wr      (rx_wr),
        .cs_n       (cs_n),
        .burst_busy (burst_busy),
        .done       (done)
    );

    spi_shift_engine u_engine (
        .clk       (clk),
        .rst       (rst),
        .start_spi (start_spi),
        .tx_data   (tx_data),
        .rx_data   (rx_data),
        .busy      (busy),
        .new_data  (new_data),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso)
    );

    byte_table u_rx_table (
        .clk   (clk),
        .rst   (rst),
        .wr    (rx_wr),
        .waddr (index),                         // same slot the byte was sent from
        .wdata (rx_data),
        .raddr (rx_raddr),
        .rdata (rx_rdata)
    );

endmodule

`default_nettype wire

/* logic/burst_sequencer.sv */
`default_nettype none

module burst_sequencer (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     start,
    input  wire spi_burst_pkg::xfer_cnt_t xfer_count,
    input  wire logic                     busy,
    input  wire logic                     new_data,
    output spi_burst_pkg::xfer_idx_t      index,
    output logic                          start_spi,
    output logic                          rx_wr,
    output logic                          cs_n,
    output logic                          burst_busy,
    output logic                          done
);
    import spi_burst_pkg::*;

    seq_state_t state;
    xfer_cnt_t  count_q;
    logic       last_byte;

    // byte accepted this cycle goes straight into the rx table
    assign rx_wr     = (state == SEQ_RUNNING) && new_data && !busy;
    assign last_byte = (xfer_cnt_t'(index) == count_q - xfer_cnt_t'(1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // burst state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SEQ_IDLE;
            index      <= '0;
            count_q    <= '0;
            start_spi  <= 1'b0;
            cs_n       <= 1'b1;
            burst_busy <= 1'b0;
            done       <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    index <= '0;
                    cs_n  <= 1'b1;
                    if (start) begin
                        count_q    <= xfer_count;
                        burst_busy <= 1'b1;
                        state      <= SEQ_STARTING;
                    end
                end
                SEQ_STARTING: begin
                    cs_n      <= 1'b0;
                    start_spi <= 1'b1;
                    state     <= SEQ_DELAY;
                end
                SEQ_DELAY: begin
                    start_spi <= 1'b0;          // engine raises busy on this edge
                    state     <= SEQ_RUNNING;
                end
                SEQ_RUNNING: begin
                    if (new_data && !busy) begin
                        if (last_byte) begin
                            done  <= 1'b1;
                            cs_n  <= 1'b1;
                            state <= SEQ_FINISH;
                        end else begin
                            index <= index + 1'b1;
                            state <= SEQ_STARTING;
                        end
                    end
                end
                SEQ_FINISH: begin
                    done       <= 1'b0;
                    burst_busy <= 1'b0;         // held through the done cycle
                    state      <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/spi_shift_engine.sv */
`default_nettype none

`include "spi_burst_cfg.svh"

module spi_shift_engine (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start_spi,
    input  wire spi_bus_pkg::spi_byte_t tx_data,
    output spi_bus_pkg::spi_byte_t      rx_data,
    output logic                        busy,
    output logic                        new_data,
    output logic                        sclk,
    output logic                        mosi,
    input  wire logic                   miso
);
    import spi_bus_pkg::*;

    localparam int DIV   = `SPI_BURST_CLK_DIV;
    localparam int DIV_W = $clog2(DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             half_done;
    bit_cnt_t         bit_cnt;
    spi_byte_t        tx_sr;
    spi_byte_t        rx_sr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sclk divider and bit sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign half_done = (div_cnt == DIV_W'(DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            new_data <= 1'b0;
            sclk     <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            tx_sr    <= '0;
        end else begin
            new_data <= 1'b0;
            if (!busy) begin
                if (start_spi) begin            // ignored while busy
                    busy    <= 1'b1;
                    sclk    <= 1'b0;
                    div_cnt <= '0;
                    bit_cnt <= bit_cnt_t'(7);
                    tx_sr   <= tx_data;         // msb goes out before first rise
                end
            end else if (half_done) begin
                div_cnt <= '0;
                if (!sclk) begin
                    sclk <= 1'b1;               // rising edge, miso sampled below
                end else begin
                    sclk <= 1'b0;               // falling edge
                    if (bit_cnt == '0) begin
                        busy     <= 1'b0;       // byte complete
                        new_data <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                        tx_sr   <= {tx_sr[6:0], 1'b0};
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive shift register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (busy && half_done && !sclk) begin
            rx_sr <= {rx_sr[6:0], miso};        // same edge that raises sclk
        end
    end

    assign mosi    = tx_sr[7];
    assign rx_data = rx_sr;                     // stable from last rise to next start

endmodule

`default_nettype wire

/* logic/byte_table.sv */
`default_nettype none

`include "spi_burst_cfg.svh"

module byte_table (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   wr,
    input  wire spi_burst_pkg::xfer_idx_t waddr,
    input  wire spi_bus_pkg::spi_byte_t   wdata,
    input  wire spi_burst_pkg::xfer_idx_t raddr,
    output spi_bus_pkg::spi_byte_t      rdata
);
    import spi_bus_pkg::*;

    spi_byte_t mem [`SPI_BURST_MAX_XFERS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SPI_BURST_MAX_XFERS; i++) begin
                mem[i] <= '0;                   // table reads zero after reset
            end
        end else if (wr) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];                  // combinational read

endmodule

`default_nettype wire

/* logic/spi_burst_pkg.sv */
`default_nettype none

`include "spi_burst_cfg.svh"

package spi_burst_pkg;

    localparam int XFER_IDX_W = (`SPI_BURST_MAX_XFERS > 1) ? $clog2(`SPI_BURST_MAX_XFERS) : 1;
    localparam int XFER_CNT_W = $clog2(`SPI_BURST_MAX_XFERS + 1);

    typedef logic [XFER_IDX_W-1:0] xfer_idx_t;  // table slot
    typedef logic [XFER_CNT_W-1:0] xfer_cnt_t;  // burst length, 1 to max

    typedef enum logic [2:0] {SEQ_IDLE, SEQ_STARTING, SEQ_DELAY, SEQ_RUNNING, SEQ_FINISH} seq_state_t;

endpackage

`default_nettype wire

/* logic/spi_bus_pkg.sv */
`default_nettype none

package spi_bus_pkg;

    // one byte as it travels on mosi / miso
    typedef logic [7:0] spi_byte_t;

    // bit position inside a byte, msb first
    typedef logic [2:0] bit_cnt_t;

endpackage

`default_nettype wire

/* logic/spi_burst_cfg.svh */
`ifndef SPI_BURST_CFG_SVH
`define SPI_BURST_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// burst master build constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SPI_BURST_MAX_XFERS 8   // table depth, longest legal burst

`define SPI_BURST_CLK_DIV 2     // clk cycles per sclk half-period, min 2

`endif
